/* verilog/lk_geom_pkg.sv */
// ----------------------------------------------------------
// image and patch geometry for the tracker control path
// 64x64 images, 33x33 patches, feature point legal for 16..47
// ----------------------------------------------------------

package lk_geom_pkg;

    // ------------------------------------------------------------
    // image and patch size
    // ------------------------------------------------------------
    localparam int ROWS   = 64;           // image height
    localparam int COLS   = 64;           // image width
    localparam int PR     = 16;           // patch half size in rows, floor(33/2)
    localparam int PC     = 16;           // patch half size in cols
    localparam int IMSIZE = ROWS * COLS;  // pixels per image

    localparam int ROW_BITS = $clog2(ROWS);   // 6
    localparam int COL_BITS = $clog2(COLS);   // 6
    localparam int IM_BITS  = $clog2(IMSIZE); // 12

    // ------------------------------------------------------------
    // sub-pixel fractions for bilinear interpolation
    // ------------------------------------------------------------
    // image 1 only needs quarter steps, from r/2 and r/4 on the coarser layers
    localparam int FRAC1_BITS = 2;
    // image 2 carries the rounded fraction of the accumulated displacement
    localparam int FRAC2_BITS = 10;

    // ------------------------------------------------------------
    // coordinate and address types
    // ------------------------------------------------------------
    typedef logic [ROW_BITS-1:0] row_t;    // integer row of the feature point
    typedef logic [COL_BITS-1:0] col_t;    // integer column of the feature point
    typedef logic [IM_BITS-1:0]  addr_t;   // linear pixel address, row major

    typedef logic [FRAC1_BITS-1:0] frac1_t;  // image 1 fraction
    typedef logic [FRAC2_BITS-1:0] frac2_t;  // image 2 fraction

endpackage

/* verilog/lk_ctrl_pkg.sv */
// ----------------------------------------------------------
// sequencer states, iteration limits and convergence bound
// displacements are Q6.26, k wraps at 16 and never nears it
// ----------------------------------------------------------

package lk_ctrl_pkg;

    // ------------------------------------------------------------
    // iteration control
    // ------------------------------------------------------------
    localparam int K_THRESH   = 6;   // solves per layer before giving up
    localparam int ETA_THRESH = 4;   // bound is 2^-ETA_THRESH pixel
    localparam int K_BITS     = 4;
    localparam int LAYER_BITS = 2;

    // ------------------------------------------------------------
    // displacement format
    // ------------------------------------------------------------
    localparam int D_BITS     = 32;
    localparam int DFRAC_BITS = 26;  // fraction bits of dr and dc

    typedef logic signed [D_BITS-1:0] d_t;  // signed displacement
    typedef logic [K_BITS-1:0]        k_t;  // solve counter in the current layer
    typedef logic [LAYER_BITS-1:0]    layer_t;

    // magnitude bound, 1/16 pixel with the default settings
    localparam d_t ETA_LIMIT = d_t'(1) <<< (DFRAC_BITS - ETA_THRESH);

    localparam layer_t TOP_LAYER = layer_t'(2);  // coarsest pyramid layer

    // ------------------------------------------------------------
    // sequencer states, in run order
    // ------------------------------------------------------------
    // order matters, drdc_en is decoded as state > find_g
    typedef enum logic [4:0] {
        idle,         // waiting for start
        init1,        // patch address registered
        extract,      // patch extraction and pyramid build
        init2,        // load layer 2 fifo address
        find_g,       // first gradient pass on layer 2
        find_d_l2,    // first displacement solve
        init3, l2_iterate, l2_check,
        init4_1, init4, l1_iterate, l1_check,
        init5_1, init5, l0_iterate, l0_check,
        stop          // one cycle before idle
    } seq_state_t;

endpackage

/* verilog/point_decode.sv */
// ----------------------------------------------------------
// feature point to patch start address and image 1 fractions
// address is only meaningful for r and c in PR..ROWS-PR-1
// ----------------------------------------------------------
`timescale 1ns/1ps

module point_decode
    import lk_geom_pkg::*;
(
    input  logic   clk,
    input  logic   reset,
    input  logic   busy,          // from the sequencer, low only in idle
    input  row_t   r,
    input  col_t   c,
    output addr_t  start_address, // top left corner of the patch
    output frac1_t r_frac1,       // layer 1 fraction of r/2
    output frac1_t c_frac1,
    output frac1_t r_frac2,       // layer 2 fraction of r/4
    output frac1_t c_frac2
);

    addr_t patch_addr;

    // (r - PR) * COLS + (c - PC), wrapped to the address width
    assign patch_addr = addr_t'((int'(r) - PR) * COLS + (int'(c) - PC));

    // ------------------------------------------------------------
    // start address register
    // ------------------------------------------------------------
    // tracks r and c every cycle while idle, so the value is ready in init1
    // and freezes to zero once the run starts
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            start_address <= '0;
        end else if (!busy) begin
            start_address <= patch_addr;
        end else begin
            start_address <= '0;   // address generator has latched it by now
        end
    end

    // ------------------------------------------------------------
    // image 1 fractions
    // ------------------------------------------------------------
    // halving r leaves r[0] as the .5 bit, in quarter units that is {r[0], 0}
    assign r_frac1 = {r[0], 1'b0};
    assign c_frac1 = {c[0], 1'b0};

    // quartering r leaves the two low bits as the fraction
    assign r_frac2 = r[1:0];
    assign c_frac2 = c[1:0];

    // integer parts are not needed here, the datapath seeds sum_d with -1

endmodule

/* verilog/convergence_check.sv */
// ----------------------------------------------------------
// eta test on the latest displacement, purely combinational
// the most negative dr or dc never passes
// ----------------------------------------------------------
`timescale 1ns/1ps

module convergence_check
    import lk_ctrl_pkg::*;
(
    input  k_t   k,           // solves counted in this layer
    input  d_t   dr,          // Q6.26 row displacement
    input  d_t   dc,          // Q6.26 col displacement
    output logic pass_dr,
    output logic pass_dc,
    output logic converged
);

    // magnitudes kept unsigned so -2^31 stays huge after negation
    logic [D_BITS-1:0] mag_dr;
    logic [D_BITS-1:0] mag_dc;
    logic              counted;

    // ------------------------------------------------------------
    // magnitude
    // ------------------------------------------------------------
    assign mag_dr = dr[D_BITS-1] ? -dr : dr;
    assign mag_dc = dc[D_BITS-1] ? -dc : dc;

    // a stale d from the previous layer must not end the new one early
    assign counted = (k != '0);

    // ------------------------------------------------------------
    // threshold compare
    // ------------------------------------------------------------
    assign pass_dr = counted && (mag_dr < $unsigned(ETA_LIMIT));
    assign pass_dc = counted && (mag_dc < $unsigned(ETA_LIMIT));

    assign converged = pass_dr && pass_dc;   // both axes must settle

endmodule

/* verilog/track_sequencer.sv */
// ----------------------------------------------------------
// pyramidal LK run sequencer, one state per cycle
// strobes are Moore outputs, decoded straight from the state
// done inputs are waited on forever, there is no timeout here
// ----------------------------------------------------------
`timescale 1ns/1ps

module track_sequencer
    import lk_geom_pkg::*, lk_ctrl_pkg::*;
(
    input  logic   clk,
    input  logic   reset,
    input  logic   start,          // sampled only in idle
    input  logic   patch_done,     // address generator finished the patch
    input  logic   invalid_addr,   // patch runs off the image
    input  logic   wn_done0,       // window pipeline done, per layer
    input  logic   wn_done1,
    input  logic   wn_done2,
    input  logic   valid_det,      // inverse solver result valid
    input  logic   converged,      // |dr| and |dc| both below eta
    input  frac2_t sumdr_frac,
    input  frac2_t sumdc_frac,
    output k_t     k,
    output layer_t layer,          // layer being worked on
    output logic   load_addr0,
    output logic   load_addr1,
    output logic   load_addr2,
    output logic   read_en,        // shared by all three fifos
    output logic   imgrad_en0,
    output logic   imgrad_en1,
    output logic   imgrad_en2,
    output logic   imgrad_rst,
    output logic   fifo0_r_en,
    output logic   fifo1_r_en,
    output logic   fifo2_r_en,
    output logic   col_count_en,
    output logic   addr_en,
    output logic   ginv_en,
    output logic   b_reset,
    output logic   shift_d,
    output logic   drdc_en,
    output logic   busy,
    output frac2_t r_frac3,        // image 2 fraction, layers 0 and 1
    output frac2_t c_frac3,
    output frac2_t r_frac4,        // image 2 fraction, layer 2
    output frac2_t c_frac4
);

    seq_state_t state, state_next;
    logic       leave_idle;
    logic       layer_done;        // current layer may advance

    assign leave_idle = (state == idle) && start;
    assign layer_done = (k == k_t'(K_THRESH)) || converged;

    // ------------------------------------------------------------
    // state register and next state
    // ------------------------------------------------------------
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state <= idle;
        end else begin
            state <= state_next;
        end
    end

    always_comb begin
        state_next = state;   // wait states hold by default
        case (state)
            idle:       if (start) state_next = init1;
            init1:      state_next = extract;
            extract: begin
                if (invalid_addr) begin
                    state_next = idle;          // bad patch, drop the point
                end else if (patch_done) begin
                    state_next = init2;
                end
            end
            init2:      state_next = find_g;
            find_g:     if (wn_done2) state_next = find_d_l2;
            find_d_l2:  if (valid_det) state_next = init3;

            // layer 2
            init3:      state_next = l2_iterate;
            l2_iterate: if (wn_done2) state_next = l2_check;
            l2_check:   state_next = !valid_det ? stop : (layer_done ? init4_1 : init3);

            // layer 1
            init4_1:    state_next = init4;
            init4:      state_next = l1_iterate;
            l1_iterate: if (wn_done1) state_next = l1_check;
            l1_check:   state_next = !valid_det ? stop : (layer_done ? init5_1 : init4);

            // layer 0, finest
            init5_1:    state_next = init5;
            init5:      state_next = l0_iterate;
            l0_iterate: if (wn_done0) state_next = l0_check;
            l0_check:   state_next = (!valid_det || layer_done) ? stop : init5;

            stop:       state_next = idle;
            default:    state_next = idle;
        endcase
    end

    // ------------------------------------------------------------
    // iteration counter and layer register
    // ------------------------------------------------------------
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            k     <= '0;
            layer <= TOP_LAYER;
        end else begin
            // clear wins over count, a new layer starts from zero solves
            if (leave_idle || shift_d) begin
                k <= '0;
            end else if (valid_det) begin
                k <= k + 1'b1;                  // wraps at 16
            end

            if (leave_idle) begin
                layer <= TOP_LAYER;             // every run starts at the top
            end else if (shift_d) begin
                layer <= layer - 1'b1;
            end
        end
    end

    // ------------------------------------------------------------
    // control strobes
    // ------------------------------------------------------------
    assign busy         = (state != idle);
    assign addr_en      = (state == extract);
    assign col_count_en = (state == extract);
    assign read_en      = (state == find_g);

    assign fifo2_r_en = (state == find_g) || (state == l2_iterate);
    assign fifo1_r_en = (state == l1_iterate);
    assign fifo0_r_en = (state == l0_iterate);
    assign imgrad_en2 = fifo2_r_en;   // gradients run alongside the fifo reads
    assign imgrad_en1 = fifo1_r_en;
    assign imgrad_en0 = fifo0_r_en;

    assign load_addr2 = (state == init2) || (state == init3);
    assign load_addr1 = (state == init4);
    assign load_addr0 = (state == init5);

    // accumulators cleared before each new iteration of any layer
    assign imgrad_rst = (state == init3) || (state == init4) || (state == init5);
    assign b_reset    = imgrad_rst;

    assign shift_d = (state == init4_1) || (state == init5_1);  // d doubles per layer
    assign ginv_en = (state == find_d_l2) || (state == l2_check)
                  || (state == l1_check) || (state == l0_check);
    assign drdc_en = (state > find_g);

    // ------------------------------------------------------------
    // image 2 fraction select
    // ------------------------------------------------------------
    // layer 0 and layer 1 fifos share one fraction path on image 2
    assign r_frac3 = (fifo0_r_en || fifo1_r_en) ? sumdr_frac : '0;
    assign c_frac3 = (fifo0_r_en || fifo1_r_en) ? sumdc_frac : '0;
    assign r_frac4 = fifo2_r_en ? sumdr_frac : '0;
    assign c_frac4 = fifo2_r_en ? sumdc_frac : '0;

endmodule

/* verilog/lk_flow_ctrl.sv */
// ----------------------------------------------------------
// control unit of the three level pyramidal LK tracker
// start is taken only while busy is low, no back-pressure
// ----------------------------------------------------------
`timescale 1ns/1ps

module lk_flow_ctrl
    import lk_geom_pkg::*, lk_ctrl_pkg::*;
(
    input  logic   clk,
    input  logic   reset,
    input  logic   start,
    input  row_t   r,             // feature point, integer
    input  col_t   c,
    input  logic   patch_done,
    input  logic   invalid_addr,
    input  logic   wn_done0,
    input  logic   wn_done1,
    input  logic   wn_done2,
    input  logic   valid_det,
    input  d_t     dr,
    input  d_t     dc,
    input  frac2_t sumdr_frac,    // rounded fraction of the summed displacement
    input  frac2_t sumdc_frac,
    output addr_t  start_address,
    output frac1_t r_frac1,
    output frac1_t c_frac1,
    output frac1_t r_frac2,
    output frac1_t c_frac2,
    output frac2_t r_frac3,
    output frac2_t c_frac3,
    output frac2_t r_frac4,
    output frac2_t c_frac4,
    output logic   load_addr0,
    output logic   load_addr1,
    output logic   load_addr2,
    output logic   read_en,
    output logic   imgrad_en0,
    output logic   imgrad_en1,
    output logic   imgrad_en2,
    output logic   imgrad_rst,    // one reset for all three gradient blocks
    output logic   fifo0_r_en,
    output logic   fifo1_r_en,
    output logic   fifo2_r_en,
    output logic   col_count_en,
    output logic   addr_en,
    output logic   ginv_en,
    output logic   b_reset,
    output logic   shift_d,
    output logic   drdc_en,
    output logic   pass_dr,
    output logic   pass_dc,
    output logic   busy,
    output layer_t layer
);

    k_t   k;           // solve count, sequencer to convergence test
    logic converged;

    point_decode decode (
        .clk, .reset, .busy, .r, .c, .start_address,
        .r_frac1, .c_frac1, .r_frac2, .c_frac2
    );

    track_sequencer execute (
        .clk, .reset, .start, .patch_done, .invalid_addr,
        .wn_done0, .wn_done1, .wn_done2, .valid_det, .converged,
        .sumdr_frac, .sumdc_frac, .k, .layer,
        .load_addr0, .load_addr1, .load_addr2, .read_en,
        .imgrad_en0, .imgrad_en1, .imgrad_en2, .imgrad_rst,
        .fifo0_r_en, .fifo1_r_en, .fifo2_r_en, .col_count_en, .addr_en,
        .ginv_en, .b_reset, .shift_d, .drdc_en, .busy,
        .r_frac3, .c_frac3, .r_frac4, .c_frac4
    );

    convergence_check result (
        .k, .dr, .dc, .pass_dr, .pass_dc, .converged
    );

endmodule

/* test/lk_flow_ctrl_properties.sv */
// ----------------------------------------------------------
// sequencer properties bound into every track_sequencer
// ----------------------------------------------------------
`timescale 1ns/1ps

module track_sequencer_properties
    import lk_ctrl_pkg::*;
(
    input logic       clk,
    input logic       reset,
    input logic       start,
    input seq_state_t state,
    input logic       busy,
    input logic       fifo0_r_en,
    input logic       fifo1_r_en,
    input logic       fifo2_r_en,
    input logic       shift_d,
    input layer_t     layer,
    input k_t         k
);

    // idle is left only on start, and busy follows at once
    assert property (@(posedge clk) disable iff (reset)
                     (state == idle) |=> (busy == $past(start)))
        else $error("busy did not follow start out of the idle state");
    assert property (@(posedge clk) disable iff (reset)
                     $onehot0({fifo0_r_en, fifo1_r_en, fifo2_r_en}))
        else $error("more than one fifo read enable is high");
    assert property (@(posedge clk) disable iff (reset)
                     shift_d |=> layer == layer_t'($past(layer) - layer_t'(1)))
        else $error("layer did not step down after shift_d");
    assert property (@(posedge clk) disable iff (reset) shift_d |=> k == k_t'(0))
        else $error("k was not cleared after shift_d");

endmodule

bind track_sequencer track_sequencer_properties props_i (
    .clk(clk), .reset(reset), .start(start), .state(state), .busy(busy),
    .fifo0_r_en(fifo0_r_en), .fifo1_r_en(fifo1_r_en), .fifo2_r_en(fifo2_r_en),
    .shift_d(shift_d), .layer(layer), .k(k)
);

/* test/lk_flow_ctrl_tb.sv */
// ----------------------------------------------------------
// random run testbench for lk_flow_ctrl with a fixed seed
// cycle model checked 1 ns after each edge
// inputs move 2 ns after each edge
// ----------------------------------------------------------
`timescale 1ns/1ps

module lk_flow_ctrl_tb
    import lk_geom_pkg::*, lk_ctrl_pkg::*;
();

    localparam int NUM_RUNS       = 200;   // start requests accepted
    localparam int RUN_CYCLES     = 400;   // generous bound for one run
    localparam int RESET_CYCLES   = 16;
    localparam int TIMEOUT_CYCLES = NUM_RUNS * RUN_CYCLES + RESET_CYCLES;

    logic   clk, reset, start, patch_done, invalid_addr, valid_det;
    logic   wn_done0, wn_done1, wn_done2;
    row_t   r;
    col_t   c;
    d_t     dr, dc;
    frac2_t sumdr_frac, sumdc_frac;
    addr_t  start_address;
    frac1_t r_frac1, c_frac1, r_frac2, c_frac2;
    frac2_t r_frac3, c_frac3, r_frac4, c_frac4;
    logic   load_addr0, load_addr1, load_addr2, read_en;
    logic   imgrad_en0, imgrad_en1, imgrad_en2, imgrad_rst;
    logic   fifo0_r_en, fifo1_r_en, fifo2_r_en;
    logic   col_count_en, addr_en, ginv_en, b_reset, shift_d, drdc_en;
    logic   pass_dr, pass_dc, busy;
    layer_t layer;

    // reference model state
    seq_state_t ms;
    k_t         mk;
    layer_t     ml;
    addr_t      maddr;
    int         runs_started;
    int         check_count;
    int         mismatch_count;
    int         cycle_count;

    lk_flow_ctrl dut_i (.*);

    initial begin : clock_gen
        clk = 1'b0;
        forever #10 clk = ~clk;   // 20 ns period
    end

    // ------------------------------------------------------------
    // compare tasks per result type
    // ------------------------------------------------------------
    task automatic compare_addr(addr_t got, addr_t exp, string name);
        check_count++;
        if (got !== exp) begin
            mismatch_count++;
            $display("mismatch at %0t: %s is %0h, expected %0h", $time, name, got, exp);
        end
    endtask

    task automatic compare_frac1(frac1_t got, frac1_t exp, string name);
        check_count++;
        if (got !== exp) begin
            mismatch_count++;
            $display("mismatch at %0t: %s is %0h, expected %0h", $time, name, got, exp);
        end
    endtask

    task automatic compare_frac2(frac2_t got, frac2_t exp, string name);
        check_count++;
        if (got !== exp) begin
            mismatch_count++;
            $display("mismatch at %0t: %s is %0h, expected %0h", $time, name, got, exp);
        end
    endtask

    task automatic compare_layer(layer_t got, layer_t exp, string name);
        check_count++;
        if (got !== exp) begin
            mismatch_count++;
            $display("mismatch at %0t: %s is %0d, expected %0d", $time, name, got, exp);
        end
    endtask

    task automatic compare_strobes(logic got, logic exp, string name);
        check_count++;
        if (got !== exp) begin
            mismatch_count++;
            $display("mismatch at %0t: %s is %b, expected %b (state %s)",
                     $time, name, got, exp, ms.name());
        end
    endtask

    // ------------------------------------------------------------
    // reference rules
    // ------------------------------------------------------------
    function automatic addr_t patch_address(row_t rr, col_t cc);
        int a;
        a = int'(rr) * COLS + int'(cc) - (PR * COLS + PC);
        return addr_t'(a & (IMSIZE - 1));   // modulo 4096
    endfunction

    // |d| below 2^(DFRAC_BITS-ETA_THRESH) once a solve has counted
    function automatic logic below_eta(k_t kk, d_t d);
        longint mag;
        mag = (d < 0) ? -longint'(d) : longint'(d);
        return (kk != k_t'(0)) && (mag < (longint'(1) << (DFRAC_BITS - ETA_THRESH)));
    endfunction

    task automatic model_step();
        seq_state_t nxt;
        logic       leave;
        logic       adv;
        logic       shift;
        nxt   = ms;
        leave = (ms == idle) && start;
        shift = (ms == init4_1) || (ms == init5_1);
        adv   = (mk == k_t'(K_THRESH)) || (below_eta(mk, dr) && below_eta(mk, dc));
        case (ms)
            idle:       nxt = start ? init1 : idle;
            init1:      nxt = extract;
            extract:    nxt = invalid_addr ? idle : (patch_done ? init2 : extract);
            init2:      nxt = find_g;
            find_g:     nxt = wn_done2 ? find_d_l2 : find_g;
            find_d_l2:  nxt = valid_det ? init3 : find_d_l2;
            init3:      nxt = l2_iterate;
            l2_iterate: nxt = wn_done2 ? l2_check : l2_iterate;
            l2_check:   nxt = !valid_det ? stop : (adv ? init4_1 : init3);
            init4_1:    nxt = init4;
            init4:      nxt = l1_iterate;
            l1_iterate: nxt = wn_done1 ? l1_check : l1_iterate;
            l1_check:   nxt = !valid_det ? stop : (adv ? init5_1 : init4);
            init5_1:    nxt = init5;
            init5:      nxt = l0_iterate;
            l0_iterate: nxt = wn_done0 ? l0_check : l0_iterate;
            l0_check:   nxt = !valid_det ? stop : (adv ? stop : init5);
            default:    nxt = idle;   // stop
        endcase
        if (leave || shift) begin
            mk = k_t'(0);
        end else if (valid_det) begin
            mk = mk + k_t'(1);        // wraps at 16
        end
        if (leave) begin
            ml = layer_t'(2);
        end else if (shift) begin
            ml = ml - layer_t'(1);
        end
        maddr = (ms == idle) ? patch_address(r, c) : addr_t'(0);
        if (leave) runs_started++;
        ms = nxt;
    endtask

    task automatic check_outputs();
        logic rd01;   // layer 0 or 1 fifo read
        logic rd2;
        rd01 = (ms == l1_iterate) || (ms == l0_iterate);
        rd2  = (ms == find_g) || (ms == l2_iterate);
        compare_addr(start_address, maddr, "start_address");
        compare_layer(layer, ml, "layer");
        // fraction of r/2 and r/4 in quarter pixel units
        compare_frac1(r_frac1, frac1_t'((r % 2) * 2), "r_frac1");
        compare_frac1(c_frac1, frac1_t'((c % 2) * 2), "c_frac1");
        compare_frac1(r_frac2, frac1_t'(r % 4), "r_frac2");
        compare_frac1(c_frac2, frac1_t'(c % 4), "c_frac2");
        compare_frac2(r_frac3, rd01 ? sumdr_frac : frac2_t'(0), "r_frac3");
        compare_frac2(c_frac3, rd01 ? sumdc_frac : frac2_t'(0), "c_frac3");
        compare_frac2(r_frac4, rd2 ? sumdr_frac : frac2_t'(0), "r_frac4");
        compare_frac2(c_frac4, rd2 ? sumdc_frac : frac2_t'(0), "c_frac4");
        compare_strobes(busy, ms != idle, "busy");
        compare_strobes(addr_en, ms == extract, "addr_en");
        compare_strobes(col_count_en, ms == extract, "col_count_en");
        compare_strobes(read_en, ms == find_g, "read_en");
        compare_strobes(fifo2_r_en, rd2, "fifo2_r_en");
        compare_strobes(imgrad_en2, rd2, "imgrad_en2");
        compare_strobes(fifo1_r_en, ms == l1_iterate, "fifo1_r_en");
        compare_strobes(imgrad_en1, ms == l1_iterate, "imgrad_en1");
        compare_strobes(fifo0_r_en, ms == l0_iterate, "fifo0_r_en");
        compare_strobes(imgrad_en0, ms == l0_iterate, "imgrad_en0");
        compare_strobes(load_addr2, (ms == init2) || (ms == init3), "load_addr2");
        compare_strobes(load_addr1, ms == init4, "load_addr1");
        compare_strobes(load_addr0, ms == init5, "load_addr0");
        compare_strobes(imgrad_rst, (ms == init3) || (ms == init4) || (ms == init5),
                        "imgrad_rst");
        compare_strobes(b_reset, (ms == init3) || (ms == init4) || (ms == init5), "b_reset");
        compare_strobes(shift_d, (ms == init4_1) || (ms == init5_1), "shift_d");
        compare_strobes(ginv_en, (ms == find_d_l2) || (ms == l2_check)
                        || (ms == l1_check) || (ms == l0_check), "ginv_en");
        compare_strobes(drdc_en, ms > find_g, "drdc_en");
        compare_strobes(pass_dr, below_eta(mk, dr), "pass_dr");
        compare_strobes(pass_dc, below_eta(mk, dc), "pass_dc");
    endtask

    // ------------------------------------------------------------
    // stimulus
    // ------------------------------------------------------------
    function automatic d_t draw_displacement();
        int sel;
        sel = int'($urandom % 32);
        if (sel == 0) return d_t'(32'h8000_0000);               // most negative
        if (sel < 16) return d_t'(int'($urandom & 32'h7f_ffff) - 4194304);  // near eta
        return d_t'($urandom);
    endfunction

    task automatic drive_inputs();
        logic in_check;
        in_check     = (ms == l2_check) || (ms == l1_check) || (ms == l0_check);
        start        = (runs_started < NUM_RUNS) && ($urandom % 2 == 0);
        r            = row_t'(16 + $urandom % 32);   // legal points only
        c            = col_t'(16 + $urandom % 32);
        patch_done   = ($urandom % 4 == 0);
        invalid_addr = ($urandom % 16 == 0);
        wn_done0     = ($urandom % 4 == 0);
        wn_done1     = ($urandom % 4 == 0);
        wn_done2     = ($urandom % 4 == 0);
        if (in_check) begin
            valid_det = ($urandom % 16 != 0);
        end else if (ms == find_d_l2) begin
            valid_det = ($urandom % 4 == 0);
        end else begin
            valid_det = 1'b0;          // solver idle outside its states
        end
        dr         = draw_displacement();
        dc         = draw_displacement();
        sumdr_frac = frac2_t'($urandom);
        sumdc_frac = frac2_t'($urandom);
    endtask

    // ------------------------------------------------------------
    // main sequence
    // ------------------------------------------------------------
    initial begin : main
        void'($urandom(32'hddcfd87b));
        reset = 1'b1;
        {start, patch_done, invalid_addr, valid_det} = '0;
        {wn_done0, wn_done1, wn_done2} = '0;
        {r, c, dr, dc, sumdr_frac, sumdc_frac} = '0;
        ms = idle;
        mk = k_t'(0);
        ml = layer_t'(2);
        maddr = addr_t'(0);
        runs_started = 0;
        check_count = 0;
        mismatch_count = 0;
        repeat (RESET_CYCLES) @(posedge clk);
        #2 reset = 1'b0;
        while (!(runs_started >= NUM_RUNS && ms == idle)) begin
            @(posedge clk);
            model_step();
            #1 check_outputs();
            #1 drive_inputs();
        end
        $display("runs %0d, checks %0d, mismatches %0d", runs_started, check_count,
                 mismatch_count);
        if (mismatch_count == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

    initial begin : watchdog
        cycle_count = 0;
        while (cycle_count < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("timeout: the runs did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("ERRORS FOUND");
        $finish;
    end

endmodule

/* flist.f */
verilog/lk_geom_pkg.sv
verilog/lk_ctrl_pkg.sv
verilog/point_decode.sv
verilog/convergence_check.sv
verilog/track_sequencer.sv
verilog/lk_flow_ctrl.sv
test/lk_flow_ctrl_properties.sv
test/lk_flow_ctrl_tb.sv

/* Makefile */
# Verilator build and run for the lk_flow_ctrl testbench

VERILATOR ?= verilator
TOP       ?= lk_flow_ctrl_tb
RTL_TOP   ?= lk_flow_ctrl
FLIST     ?= flist.f
BUILD_DIR ?= obj_dir
SIM_LOG   ?= sim.log
VFLAGS    ?= --binary --timing --assert
BIN       := $(BUILD_DIR)/V$(TOP)

.PHONY: all run lint clean

all: run

$(BIN): $(FLIST) $(shell cat $(FLIST))
	$(VERILATOR) $(VFLAGS) -Mdir $(BUILD_DIR) --top-module $(TOP) -f $(FLIST)

run: $(BIN)
	-$(BIN) > $(SIM_LOG) 2>&1
	cat $(SIM_LOG)
	@if grep -q "ERRORS FOUND" $(SIM_LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q "NO ERRORS" $(SIM_LOG); then echo "simulation incomplete"; exit 1; fi

lint:
	$(VERILATOR) --lint-only --timing --assert --top-module $(TOP) -f $(FLIST)

clean:
	rm -rf $(BUILD_DIR) $(SIM_LOG)
